/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_exu_top -Mdir obj_dir -f sources.f

run: compile
	./obj_dir/Vtb_exu_top | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/exu_checker.sv */
`timescale 1ns/100ps
module exu_checker import exu_pkg::*; (
  input logic            clk,
  input logic            rst_n_i,
  input ex_req_t         req_i,
  input logic            mem_stall_i,
  input logic            stall_o,
  input ex_mem_t         ex_mem_o,
  input logic            redirect_valid_o,
  input logic [XLEN-1:0] redirect_pc_o,
  input bpu_upd_t        bpu_upd_o
);

  ex_mem_t exp_q[$];
  string   test_name = "reset";
  int      checks    = 0;
  int      errors    = 0;
  int      pending   = 0;
  logic    due_q     = 1'b0;   // a result must show after the coming edge

  function automatic logic [63:0] divrem(logic [63:0] a, logic [63:0] b, logic sgn, logic rem);
    logic signed [63:0] sa, sb;
    sa = a;
    sb = b;
    if (b == '0) return rem ? a : '1;
    if (sgn && a == 64'h8000_0000_0000_0000 && b == '1) return rem ? '0 : a;
    if (sgn) begin
      if (rem) return sa % sb;
      return sa / sb;
    end
    if (rem) return a % b;
    return a / b;
  endfunction

  function automatic logic [63:0] full_ref(alu_op_e op, logic [63:0] a, logic [63:0] b);
    logic signed [63:0]  sa, sb;
    logic signed [127:0] wa, wb, wbu;
    logic [127:0]        p;
    sa  = a;
    sb  = b;
    wa  = sa;
    wb  = sb;
    wbu = {64'b0, b};
    case (op)
      ALU_ADD:    return a + b;
      ALU_SUB:    return a - b;
      ALU_SLL:    return a << b[5:0];
      ALU_SLT:    return {63'b0, sa < sb};
      ALU_SLTU:   return {63'b0, a < b};
      ALU_XOR:    return a ^ b;
      ALU_SRL:    return a >> b[5:0];
      ALU_SRA:    return sa >>> b[5:0];
      ALU_OR:     return a | b;
      ALU_AND:    return a & b;
      ALU_MUL:    return a * b;
      ALU_MULH:   p = wa * wb;
      ALU_MULHSU: p = wa * wbu;
      ALU_MULHU:  p = {64'b0, a} * {64'b0, b};
      ALU_DIV:    return divrem(a, b, 1'b1, 1'b0);
      ALU_DIVU:   return divrem(a, b, 1'b0, 1'b0);
      ALU_REM:    return divrem(a, b, 1'b1, 1'b1);
      ALU_REMU:   return divrem(a, b, 1'b0, 1'b1);
      default:    p = '0;
    endcase
    return p[127:64];   // high half of the product
  endfunction

  function automatic logic [63:0] alu_ref(alu_op_e op, logic [63:0] a, logic [63:0] b,
                                          logic word);
    logic [63:0]        ae, be, r;
    logic signed [31:0] sa32;
    if (!word) return full_ref(op, a, b);
    sa32 = a[31:0];
    if (op == ALU_DIVU || op == ALU_REMU) begin
      ae = {32'b0, a[31:0]};
      be = {32'b0, b[31:0]};
    end else begin
      ae = {{32{a[31]}}, a[31:0]};
      be = {{32{b[31]}}, b[31:0]};
    end
    case (op)
      ALU_SLL: r = a << b[4:0];
      ALU_SRL: r = {32'b0, a[31:0]} >> b[4:0];
      ALU_SRA: r = sa32 >>> b[4:0];
      default: r = full_ref(op, ae, be);
    endcase
    return {{32{r[31]}}, r[31:0]};
  endfunction

  function automatic logic cond_ref(alu_op_e op, logic [63:0] a, logic [63:0] b);
    case (op)
      ALU_BEQ:  return a == b;
      ALU_BNE:  return a != b;
      ALU_BLT:  return $signed(a) < $signed(b);
      ALU_BGE:  return $signed(a) >= $signed(b);
      ALU_BLTU: return a < b;
      ALU_BGEU: return a >= b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic ex_mem_t exu_model(ex_req_t r);
    ex_mem_t     e;
    logic [63:0] up, src;
    up          = {r.imm[63:12], 12'b0};
    src         = r.csr_imm_valid ? {59'b0, r.csr_imm} : r.rs1_data;
    e.valid     = 1'b1;
    e.pc        = r.pc;
    e.inst      = r.inst;
    e.rd        = r.rd;
    e.rs2_data  = r.rs2_data;
    e.mem_op    = r.mem_op;
    e.csr_addr  = r.csr_addr;
    e.csr_valid = (r.csr_op != CSR_NONE);
    case (r.csr_op)
      CSR_RW:  e.csr_data = src;
      CSR_RS:  e.csr_data = r.csr_data | src;
      CSR_RC:  e.csr_data = r.csr_data & ~src;
      default: e.csr_data = r.csr_data;
    endcase
    case (r.exc_op)
      EXC_OP:              e.alu_data = alu_ref(r.alu_op, r.rs1_data, r.rs2_data, 1'b0);
      EXC_OP32:            e.alu_data = alu_ref(r.alu_op, r.rs1_data, r.rs2_data, 1'b1);
      EXC_OPIMM:           e.alu_data = alu_ref(r.alu_op, r.rs1_data, r.imm, 1'b0);
      EXC_OPIMM32:         e.alu_data = alu_ref(r.alu_op, r.rs1_data, r.imm, 1'b1);
      EXC_BRANCH:          e.alu_data = {63'b0, cond_ref(r.alu_op, r.rs1_data, r.rs2_data)};
      EXC_JAL, EXC_JALR:   e.alu_data = r.pc + 64'd4;
      EXC_LUI:             e.alu_data = up;
      EXC_AUIPC:           e.alu_data = r.pc + up;
      EXC_LOAD, EXC_STORE: e.alu_data = r.rs1_data + r.imm;
      EXC_CSR:             e.alu_data = r.csr_data;
      default:             e.alu_data = '0;
    endcase
    return e;
  endfunction

  task automatic check_eq(input string what, input logic [511:0] exp, input logic [511:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic check_redirect(input ex_req_t r);
    logic jump, taken, mis;
    logic [63:0] target;
    jump   = (r.exc_op == EXC_JAL) || (r.exc_op == EXC_JALR);
    taken  = jump || (r.exc_op == EXC_BRANCH && cond_ref(r.alu_op, r.rs1_data, r.rs2_data));
    mis    = taken != r.bpu_taken;
    if (r.bpu_taken) target = r.pc + 64'd4;
    else if (r.exc_op == EXC_JALR) target = r.rs1_data + r.imm;
    else target = r.pc + r.imm;
    check_eq("redirect_valid", 512'(mis), 512'(redirect_valid_o));
    if (mis) check_eq("redirect_pc", 512'(target), 512'(redirect_pc_o));
    check_eq("bpu_upd.valid", 512'(jump || r.exc_op == EXC_BRANCH), 512'(bpu_upd_o.valid));
    if (jump || r.exc_op == EXC_BRANCH) begin
      check_eq("bpu_upd.pc", 512'(r.pc[31:0]), 512'(bpu_upd_o.pc));
      check_eq("bpu_upd.taken", 512'(taken), 512'(bpu_upd_o.taken));
      check_eq("bpu_upd.is_branch", 512'(r.exc_op == EXC_BRANCH), 512'(bpu_upd_o.is_branch));
    end
  endtask

  // everything sampled mid-cycle, inputs and registers are settled here
  always @(negedge clk) begin
    if (!rst_n_i) begin
      due_q = 1'b0;
    end else begin
      if (due_q && !ex_mem_o.valid) begin
        errors++;
        $display("ERROR %s: no result in ex_mem_o one cycle after acceptance", test_name);
      end
      due_q = 1'b0;
      if (ex_mem_o.valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR %s: result in ex_mem_o with nothing expected", test_name);
        end else begin
          check_eq("alu_data", 512'(exp_q[0].alu_data), 512'(ex_mem_o.alu_data));
          check_eq("ex_mem", 512'(exp_q[0]), 512'(ex_mem_o));
          if (!mem_stall_i) exp_q.pop_front();   // memory takes it at the next edge
        end
      end
      if (req_i.valid && !stall_o) begin
        check_redirect(req_i);
        exp_q.push_back(exu_model(req_i));
        due_q = 1'b1;
      end
      pending = exp_q.size();
    end
  end

endmodule

/* dv/tb_exu_top.sv */
`timescale 1ns/100ps
module tb_exu_top import exu_pkg::*; ();

  logic            clk;
  logic            rst_n_i;
  ex_req_t         req;
  logic            mem_stall;
  logic            mem_stall_en;
  logic            stall;
  ex_mem_t         ex_mem;
  logic            redirect_valid;
  logic [XLEN-1:0] redirect_pc;
  bpu_upd_t        bpu_upd;
  integer          seed;
  int              err_before;
  logic            hung;

  exu_top dut0 (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_i           (req),
    .mem_stall_i     (mem_stall),
    .stall_o         (stall),
    .ex_mem_o        (ex_mem),
    .redirect_valid_o(redirect_valid),
    .redirect_pc_o   (redirect_pc),
    .bpu_upd_o       (bpu_upd)
  );

  exu_checker chk0 (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_i           (req),
    .mem_stall_i     (mem_stall),
    .stall_o         (stall),
    .ex_mem_o        (ex_mem),
    .redirect_valid_o(redirect_valid),
    .redirect_pc_o   (redirect_pc),
    .bpu_upd_o       (bpu_upd)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [63:0] rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic int pick(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic pick_stall();
    return mem_stall_en && (pick(4) == 0);
  endfunction

  function automatic ex_req_t base_req(exc_op_e cls);
    ex_req_t     r;
    logic [63:0] t;
    t               = rnd64();
    r               = '0;
    r.valid         = 1'b1;
    r.pc            = {t[63:2], 2'b00};
    r.inst          = $random(seed);
    r.rd            = 5'(pick(32));
    r.rs1_data      = rnd64();
    r.rs2_data      = rnd64();
    r.imm           = rnd64();
    r.csr_addr      = 12'(pick(4096));
    r.csr_data      = rnd64();
    r.csr_imm       = 5'(pick(32));
    r.exc_op        = cls;
    r.alu_op        = ALU_ADD;
    r.mem_op        = MEM_NONE;
    r.csr_op        = CSR_NONE;
    return r;
  endfunction

  // kind 0 alu, 1 branch/jump, 2 upper/mem, 3 csr, 4 mul/div
  function automatic ex_req_t rand_req(int kind);
    ex_req_t r;
    case (kind)
      0: begin
        r = base_req(exc_op_e'(4'(8 + pick(4))));   // OPIMM..OP32
        if (r.exc_op == EXC_OP32 || r.exc_op == EXC_OPIMM32) begin
          case (pick(5))
            0: r.alu_op = ALU_ADD;
            1: r.alu_op = ALU_SUB;
            2: r.alu_op = ALU_SLL;
            3: r.alu_op = ALU_SRL;
            default: r.alu_op = ALU_SRA;
          endcase
        end else begin
          r.alu_op = alu_op_e'(5'(pick(10)));
        end
      end
      1: begin
        r = base_req(exc_op_e'(4'(pick(3) == 0 ? 3 : (pick(2) == 0 ? 4 : 7))));
        if (r.exc_op == EXC_BRANCH) r.alu_op = alu_op_e'(5'(18 + pick(6)));
        if (pick(2) == 0) r.rs2_data = r.rs1_data;
        r.bpu_taken = 1'(pick(2));
      end
      2: begin
        r = base_req(exc_op_e'(4'(1 + pick(6))));     // AUIPC..STORE, JAL/JALR fixed below
        if (r.exc_op == EXC_JAL || r.exc_op == EXC_JALR) r.exc_op = EXC_LUI;
        if (r.exc_op == EXC_LOAD || r.exc_op == EXC_STORE) r.mem_op = mem_op_e'(3'(1 + pick(6)));
      end
      3: begin
        r = base_req(EXC_CSR);
        r.csr_op        = csr_op_e'(2'(1 + pick(3)));
        r.csr_imm_valid = 1'(pick(2));
      end
      default: begin
        r = base_req(pick(2) == 0 ? EXC_OP : EXC_OP32);
        r.alu_op = alu_op_e'(5'(10 + pick(8)));
        if (r.exc_op == EXC_OP32 && r.alu_op inside {ALU_MULH, ALU_MULHSU, ALU_MULHU}) begin
          r.alu_op = ALU_MUL;
        end
      end
    endcase
    return r;
  endfunction

  task automatic report_hang(input string what);
    $display("ERROR: %s", what);
    hung = 1'b1;
  endtask

  // present one instruction and hold it until the stage takes it
  task automatic issue(input ex_req_t r);
    int n;
    if (hung) return;
    @(posedge clk);
    #1;
    req       = r;
    mem_stall = pick_stall();
    n = 0;
    @(negedge clk);
    while (stall && n < 200) begin
      @(posedge clk);
      #1 mem_stall = pick_stall();
      @(negedge clk);
      n++;
    end
    if (stall) begin
      report_hang("instruction was never accepted, stall_o stuck high");
      return;
    end
    @(posedge clk);
    #1;
    req.valid = 1'b0;
    mem_stall = pick_stall();
  endtask

  task automatic md_case(input alu_op_e op, input logic word, input logic [63:0] a,
                         input logic [63:0] b);
    ex_req_t r;
    r          = base_req(word ? EXC_OP32 : EXC_OP);
    r.alu_op   = op;
    r.rs1_data = a;
    r.rs2_data = b;
    issue(r);
  endtask

  task automatic start_test(input string name);
    chk0.test_name = name;
    err_before     = chk0.errors;
  endtask

  task automatic end_test();
    int n;
    if (hung) return;
    n = 0;
    @(negedge clk);
    #1;
    while (chk0.pending != 0 && n < 200) begin
      @(posedge clk);
      #1 mem_stall = pick_stall();
      @(negedge clk);
      #1;
      n++;
    end
    if (chk0.pending != 0) begin
      report_hang("expected results never left ex_mem_o");
    end else begin
      $display("test %-12s done, %0d errors", chk0.test_name, chk0.errors - err_before);
    end
  endtask

  initial begin
    seed         = 32'h1ecc_cacc;
    hung         = 1'b0;
    req          = '0;
    mem_stall    = 1'b0;
    mem_stall_en = 1'b0;
    rst_n_i      = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n_i = 1'b1;

    start_test("alu_random");
    for (int i = 0; i < 40; i++) issue(rand_req(0));
    end_test();

    start_test("branch_jump");
    for (int i = 0; i < 40; i++) issue(rand_req(1));
    end_test();

    start_test("upper_mem");
    for (int i = 0; i < 20; i++) issue(rand_req(2));
    end_test();

    start_test("csr");
    for (int i = 0; i < 20; i++) issue(rand_req(3));
    end_test();

    start_test("mul_div");
    for (int op = 10; op < 18; op++) md_case(alu_op_e'(5'(op)), 1'b0, rnd64(), rnd64());
    md_case(ALU_MUL, 1'b1, rnd64(), rnd64());
    for (int op = 14; op < 18; op++) begin
      md_case(alu_op_e'(5'(op)), 1'b1, rnd64(), rnd64());
      md_case(alu_op_e'(5'(op)), 1'b0, rnd64(), 64'd0);             // divide by zero
      md_case(alu_op_e'(5'(op)), 1'b1, rnd64(), rnd64() & 64'hffff_ffff_0000_0000);
    end
    md_case(ALU_DIV, 1'b0, 64'h8000_0000_0000_0000, '1);           // signed overflow
    md_case(ALU_REM, 1'b0, 64'h8000_0000_0000_0000, '1);
    md_case(ALU_DIV, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    md_case(ALU_REM, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    end_test();

    start_test("mem_stall");
    mem_stall_en = 1'b1;
    for (int i = 0; i < 40; i++) issue(rand_req(pick(5)));
    end_test();
    mem_stall_en = 1'b0;

    $display("checks %0d, errors %0d", chk0.checks, chk0.errors);
    if (chk0.errors == 0 && !hung) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* source/alu_top.sv */
`timescale 1ns/100ps
module alu_top import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            start_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  alu_op_e         op_i,
  input  logic            word_i,
  input  logic            md_ack_i,
  input  logic [XLEN-1:0] md_result_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_o,
  output logic            md_busy_o,
  output logic            md_done_o,
  output logic            md_req_o,
  output md_req_t         md_op_o
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP, DONE} req_state_e;

  req_state_e      state_q, state_d;
  md_req_t         md_op_q;
  logic [XLEN-1:0] md_res_q;
  logic            is_md;
  logic            eq, lt_s, lt_u;
  logic [5:0]      shamt;
  logic [XLEN-1:0] srl_src, sra_src;

  assign is_md = op_i inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                              ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};

  always_comb begin
    eq    = (a_i == b_i);
    lt_s  = ($signed(a_i) < $signed(b_i));
    lt_u  = (a_i < b_i);
    shamt = word_i ? {1'b0, b_i[4:0]} : b_i[5:0];
    // word shifts only see the low half of a
    srl_src = word_i ? {32'b0, a_i[31:0]} : a_i;
    sra_src = word_i ? {{32{a_i[31]}}, a_i[31:0]} : a_i;
  end

  always_comb begin
    case (op_i)
      ALU_BEQ:  cmp_o = eq;
      ALU_BNE:  cmp_o = !eq;
      ALU_BLT:  cmp_o = lt_s;
      ALU_BGE:  cmp_o = !lt_s;
      ALU_BLTU: cmp_o = lt_u;
      ALU_BGEU: cmp_o = !lt_u;
      default:  cmp_o = 1'b0;
    endcase
  end

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = {{XLEN-1{1'b0}}, lt_s};
      ALU_SLTU: result_o = {{XLEN-1{1'b0}}, lt_u};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = srl_src >> shamt;
      ALU_SRA:  result_o = $signed(sra_src) >>> shamt;
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU:
        result_o = {{XLEN-1{1'b0}}, cmp_o};
      default:  result_o = md_res_q;      // mul/div, captured from the unit
    endcase
  end

  // four-phase requester toward mul_div_unit
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (start_i && is_md) state_d = REQ;
      REQ:       if (md_ack_i) state_d = WAIT_DROP;
      WAIT_DROP: if (!md_ack_i) state_d = DONE;
      DONE:      if (start_i) state_d = IDLE;    // result taken by the stage
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && start_i && is_md) begin
      md_op_q <= '{op: op_i, word: word_i, a: a_i, b: b_i};
    end
    if (state_q == REQ && md_ack_i) begin
      md_res_q <= md_result_i;
    end
  end

  assign md_req_o  = (state_q == REQ);
  assign md_op_o   = md_op_q;
  assign md_done_o = (state_q == DONE) && start_i;
  assign md_busy_o = (state_q == IDLE && start_i && is_md) ||
                     (state_q == REQ) || (state_q == WAIT_DROP) ||
                     (state_q == DONE && !start_i);

endmodule

/* source/branch_resolve.sv */
`timescale 1ns/100ps
module branch_resolve import exu_pkg::*; (
  input  logic            active_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] imm_i,
  input  exc_op_e         exc_op_i,
  input  logic            cmp_i,
  input  logic            bpu_taken_i,
  output logic            redirect_valid_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output bpu_upd_t        bpu_upd_o
);

  logic            is_br, is_jal, is_jalr;
  logic            taken, mispredict;
  logic [XLEN-1:0] base, offset;

  assign is_br   = (exc_op_i == EXC_BRANCH);
  assign is_jal  = (exc_op_i == EXC_JAL);
  assign is_jalr = (exc_op_i == EXC_JALR);

  assign taken      = (cmp_i && is_br) || is_jal || is_jalr;
  assign mispredict = taken ^ bpu_taken_i;

  // predicted taken but not taken, so fall through to pc+4
  always_comb begin
    if (bpu_taken_i) begin
      base   = pc_i;
      offset = 64'd4;
    end else begin
      base   = is_jalr ? rs1_data_i : pc_i;
      offset = imm_i;
    end
  end

  assign redirect_pc_o    = base + offset;
  assign redirect_valid_o = active_i && mispredict;

  always_comb begin
    bpu_upd_o.valid     = active_i && (is_br || is_jal || is_jalr);
    bpu_upd_o.pc        = pc_i[31:0];
    bpu_upd_o.taken     = taken;
    bpu_upd_o.is_branch = is_br;
  end

endmodule

/* source/ex_mem_reg.sv */
`timescale 1ns/100ps
module ex_mem_reg import exu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    stall_i,
  input  ex_mem_t d_i,
  output ex_mem_t q_o
);

  logic    valid_q;
  ex_mem_t data_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= d_i.valid;   // bubble when nothing was accepted
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      data_q <= d_i;
    end
  end

  always_comb begin
    q_o       = data_q;
    q_o.valid = valid_q;
  end

endmodule

/* source/execute_csr.sv */
`timescale 1ns/100ps
module execute_csr import exu_pkg::*; (
  input  logic [XLEN-1:0] csr_data_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [4:0]      csr_imm_i,
  input  logic            csr_imm_valid_i,
  input  csr_op_e         csr_op_i,
  output logic [XLEN-1:0] csr_wdata_o,
  output logic            csr_wvalid_o
);

  logic [XLEN-1:0] src;

  // uimm forms take the zero-extended immediate
  assign src = csr_imm_valid_i ? {{XLEN-5{1'b0}}, csr_imm_i} : rs1_data_i;

  always_comb begin
    case (csr_op_i)
      CSR_RW:  csr_wdata_o = src;
      CSR_RS:  csr_wdata_o = csr_data_i | src;    // set bits
      CSR_RC:  csr_wdata_o = csr_data_i & ~src;   // clear bits
      default: csr_wdata_o = csr_data_i;
    endcase
  end

  assign csr_wvalid_o = (csr_op_i != CSR_NONE);

endmodule

/* source/execute_stage.sv */
`timescale 1ns/100ps
module execute_stage import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  ex_req_t         req_i,
  input  logic            hold_i,
  input  logic            md_ack_i,
  input  logic [XLEN-1:0] md_result_i,
  output logic            stall_o,
  output ex_mem_t         result_o,
  output logic            md_req_o,
  output md_req_t         md_op_o,
  output logic            redirect_valid_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output bpu_upd_t        bpu_upd_o
);

  logic [XLEN-1:0] op_a, op_b, upper_imm;
  logic [XLEN-1:0] alu_out, alu_data;
  logic [XLEN-1:0] csr_wdata;
  logic            csr_wvalid;
  logic            cmp, md_busy, md_done;
  logic            word_op, is_md, start, accept;

  assign word_op = (req_i.exc_op == EXC_OP32) || (req_i.exc_op == EXC_OPIMM32);
  assign is_md   = req_i.alu_op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                                        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  assign start   = req_i.valid && !hold_i;

  assign upper_imm = {req_i.imm[XLEN-1:12], 12'b0};

  always_comb begin
    case (req_i.exc_op)
      EXC_OP, EXC_OP32, EXC_BRANCH: begin
        op_a = req_i.rs1_data;
        op_b = req_i.rs2_data;
      end
      EXC_OPIMM, EXC_OPIMM32, EXC_LOAD, EXC_STORE: begin
        op_a = req_i.rs1_data;
        op_b = req_i.imm;                 // address for load/store
      end
      EXC_JAL, EXC_JALR: begin
        op_a = req_i.pc;
        op_b = 64'd4;                     // link address
      end
      EXC_AUIPC: begin
        op_a = req_i.pc;
        op_b = upper_imm;
      end
      EXC_LUI: begin
        op_a = '0;
        op_b = upper_imm;
      end
      EXC_CSR: begin
        op_a = '0;
        op_b = req_i.csr_data;            // old csr value goes to rd
      end
      default: begin
        op_a = '0;
        op_b = '0;
      end
    endcase
  end

  alu_top u_alu (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (start),
    .a_i        (op_a),
    .b_i        (op_b),
    .op_i       (req_i.alu_op),
    .word_i     (word_op),
    .md_ack_i   (md_ack_i),
    .md_result_i(md_result_i),
    .result_o   (alu_out),
    .cmp_o      (cmp),
    .md_busy_o  (md_busy),
    .md_done_o  (md_done),
    .md_req_o   (md_req_o),
    .md_op_o    (md_op_o)
  );

  // *W results come back as 32 bits
  assign alu_data = word_op ? {{32{alu_out[31]}}, alu_out[31:0]} : alu_out;

  execute_csr u_csr (
    .csr_data_i     (req_i.csr_data),
    .rs1_data_i     (req_i.rs1_data),
    .csr_imm_i      (req_i.csr_imm),
    .csr_imm_valid_i(req_i.csr_imm_valid),
    .csr_op_i       (req_i.csr_op),
    .csr_wdata_o    (csr_wdata),
    .csr_wvalid_o   (csr_wvalid)
  );

  assign stall_o = md_busy || hold_i;
  // mul/div only leaves on the cycle its result is ready
  assign accept  = start && (is_md ? md_done : !md_busy);

  branch_resolve u_branch (
    .active_i        (req_i.valid && !stall_o),
    .pc_i            (req_i.pc),
    .rs1_data_i      (req_i.rs1_data),
    .imm_i           (req_i.imm),
    .exc_op_i        (req_i.exc_op),
    .cmp_i           (cmp),
    .bpu_taken_i     (req_i.bpu_taken),
    .redirect_valid_o(redirect_valid_o),
    .redirect_pc_o   (redirect_pc_o),
    .bpu_upd_o       (bpu_upd_o)
  );

  always_comb begin
    result_o.valid     = accept;
    result_o.pc        = req_i.pc;
    result_o.inst      = req_i.inst;
    result_o.rd        = req_i.rd;
    result_o.rs2_data  = req_i.rs2_data;
    result_o.mem_op    = req_i.mem_op;
    result_o.alu_data  = alu_data;
    result_o.csr_addr  = req_i.csr_addr;
    result_o.csr_data  = csr_wdata;
    result_o.csr_valid = csr_wvalid;
  end

endmodule

/* source/exu_pkg.sv */
package exu_pkg;

  localparam int XLEN   = 64;
  localparam int REG_AW = 5;
  localparam int CSR_AW = 12;

  // alu opcodes, single-cycle first, then M extension, then branch conditions
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  typedef enum logic [3:0] {
    EXC_NONE, EXC_AUIPC, EXC_LUI, EXC_JAL, EXC_JALR, EXC_LOAD, EXC_STORE,
    EXC_BRANCH, EXC_OPIMM, EXC_OPIMM32, EXC_OP, EXC_OP32, EXC_CSR
  } exc_op_e;

  typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_e;

  // only carried through to memory
  typedef enum logic [2:0] {
    MEM_NONE, MEM_LB, MEM_LW, MEM_LD, MEM_SB, MEM_SW, MEM_SD
  } mem_op_e;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [31:0]       inst;
    logic              bpu_taken;     // prediction made at fetch
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
    logic [CSR_AW-1:0] csr_addr;
    logic [XLEN-1:0]   csr_data;      // old csr value
    logic [4:0]        csr_imm;
    logic              csr_imm_valid;
    alu_op_e           alu_op;
    mem_op_e           mem_op;
    exc_op_e           exc_op;
    csr_op_e           csr_op;
  } ex_req_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [31:0]       inst;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rs2_data;      // store data
    mem_op_e           mem_op;
    logic [XLEN-1:0]   alu_data;
    logic [CSR_AW-1:0] csr_addr;
    logic [XLEN-1:0]   csr_data;      // new csr value
    logic              csr_valid;
  } ex_mem_t;

  typedef struct packed {
    alu_op_e         op;
    logic            word;            // *W forms
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } md_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        taken;
    logic        is_branch;
  } bpu_upd_t;

endpackage

/* source/exu_top.sv */
`timescale 1ns/100ps
module exu_top import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  ex_req_t         req_i,
  input  logic            mem_stall_i,
  output logic            stall_o,
  output ex_mem_t         ex_mem_o,
  output logic            redirect_valid_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output bpu_upd_t        bpu_upd_o
);

  logic            md_req;
  md_req_t         md_op;
  logic            md_ack;
  logic [XLEN-1:0] md_result;
  ex_mem_t         ex_mem_d;

  execute_stage u_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_i           (req_i),
    .hold_i          (mem_stall_i),   // memory backpressure
    .md_ack_i        (md_ack),
    .md_result_i     (md_result),
    .stall_o         (stall_o),
    .result_o        (ex_mem_d),
    .md_req_o        (md_req),
    .md_op_o         (md_op),
    .redirect_valid_o(redirect_valid_o),
    .redirect_pc_o   (redirect_pc_o),
    .bpu_upd_o       (bpu_upd_o)
  );

  mul_div_unit u_md (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .md_req_i   (md_req),
    .md_op_i    (md_op),
    .md_ack_o   (md_ack),
    .md_result_o(md_result)
  );

  ex_mem_reg u_ex_mem (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .stall_i(mem_stall_i),
    .d_i    (ex_mem_d),
    .q_o    (ex_mem_o)
  );

endmodule

/* source/mul_div_unit.sv */
`timescale 1ns/100ps
module mul_div_unit import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            md_req_i,
  input  md_req_t         md_op_i,
  output logic            md_ack_o,
  output logic [XLEN-1:0] md_result_o
);

  typedef enum logic [1:0] {IDLE, RUN, ACK} md_state_e;

  md_state_e         state_q, state_d;
  logic [5:0]        cnt_q;
  logic [XLEN-1:0]   hi_q, lo_q, mb_q;   // product or remainder/quotient pair
  alu_op_e           op_q;
  logic              word_q, neg_q, rneg_q;

  logic              a_signed, b_signed, is_div, run_div;
  logic [XLEN-1:0]   a_ext, b_ext, a_mag, b_mag, min_val;
  logic              div_zero, div_ovf;
  logic [XLEN:0]     mul_sum, rem_sh, div_diff;
  logic [2*XLEN-1:0] prod;
  logic [XLEN-1:0]   quo, rem, raw;

  // operand preparation, sampled when a request is taken
  always_comb begin
    a_signed = md_op_i.op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_DIV, ALU_REM};
    b_signed = md_op_i.op inside {ALU_MUL, ALU_MULH, ALU_DIV, ALU_REM};
    is_div   = md_op_i.op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    if (md_op_i.word) begin
      a_ext   = a_signed ? {{32{md_op_i.a[31]}}, md_op_i.a[31:0]} : {32'b0, md_op_i.a[31:0]};
      b_ext   = b_signed ? {{32{md_op_i.b[31]}}, md_op_i.b[31:0]} : {32'b0, md_op_i.b[31:0]};
      min_val = {{33{1'b1}}, 31'b0};
    end else begin
      a_ext   = md_op_i.a;
      b_ext   = md_op_i.b;
      min_val = {1'b1, {XLEN-1{1'b0}}};
    end
    a_mag    = (a_signed && a_ext[XLEN-1]) ? -a_ext : a_ext;
    b_mag    = (b_signed && b_ext[XLEN-1]) ? -b_ext : b_ext;
    div_zero = is_div && (b_ext == '0);
    div_ovf  = is_div && a_signed && (a_ext == min_val) && (b_ext == '1);
  end

  // one iteration step of either algorithm
  always_comb begin
    run_div  = op_q inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    mul_sum  = {1'b0, hi_q} + (lo_q[0] ? {1'b0, mb_q} : '0);
    rem_sh   = {hi_q, lo_q[XLEN-1]};
    div_diff = rem_sh - {1'b0, mb_q};     // top bit set means no subtract
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (md_req_i) state_d = (div_zero || div_ovf) ? ACK : RUN;
      RUN:     if (cnt_q == 6'd63) state_d = ACK;
      ACK:     if (!md_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= (state_q == RUN) ? cnt_q + 6'd1 : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && md_req_i) begin
      op_q   <= md_op_i.op;
      word_q <= md_op_i.word;
      mb_q   <= b_mag;
      if (div_zero) begin
        hi_q   <= a_ext;                  // remainder is the dividend
        lo_q   <= '1;
        neg_q  <= 1'b0;
        rneg_q <= 1'b0;
      end else if (div_ovf) begin
        hi_q   <= '0;
        lo_q   <= a_ext;                  // quotient is the dividend
        neg_q  <= 1'b0;
        rneg_q <= 1'b0;
      end else begin
        hi_q   <= '0;
        lo_q   <= a_mag;
        neg_q  <= (a_signed && a_ext[XLEN-1]) ^ (b_signed && b_ext[XLEN-1]);
        rneg_q <= a_signed && a_ext[XLEN-1];
      end
    end else if (state_q == RUN) begin
      if (run_div) begin
        if (!div_diff[XLEN]) begin
          hi_q <= div_diff[XLEN-1:0];
          lo_q <= {lo_q[XLEN-2:0], 1'b1};
        end else begin
          hi_q <= rem_sh[XLEN-1:0];
          lo_q <= {lo_q[XLEN-2:0], 1'b0};
        end
      end else begin
        hi_q <= mul_sum[XLEN:1];
        lo_q <= {mul_sum[0], lo_q[XLEN-1:1]};
      end
    end
  end

  // sign fix-up, stable while ack is high
  always_comb begin
    prod = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};
    quo  = neg_q ? -lo_q : lo_q;
    rem  = rneg_q ? -hi_q : hi_q;
    case (op_q)
      ALU_MUL:                         raw = prod[XLEN-1:0];
      ALU_MULH, ALU_MULHSU, ALU_MULHU: raw = prod[2*XLEN-1:XLEN];
      ALU_DIV, ALU_DIVU:               raw = quo;
      default:                         raw = rem;
    endcase
    md_result_o = word_q ? {{32{raw[31]}}, raw[31:0]} : raw;
  end

  assign md_ack_o = (state_q == ACK);

endmodule

/* sources.f */
source/exu_pkg.sv
source/alu_top.sv
source/mul_div_unit.sv
source/execute_csr.sv
source/branch_resolve.sv
source/execute_stage.sv
source/ex_mem_reg.sv
source/exu_top.sv
dv/exu_checker.sv
dv/tb_exu_top.sv
